//--- hdl/fpm_pkg.sv
// float word union, field widths, bias, rounding mode codes and special result patterns
package fpm_pkg;

  localparam int EXP_W  = 8;
  localparam int FRAC_W = 23;
  localparam int MANT_W = 24;  // hidden one included
  localparam int PROD_W = 48;

  // radix-8 booth over a 24-bit unsigned multiplier
  localparam int NUM_PP = 9;
  localparam int PP_W   = 27;

  localparam int EXP_BIAS = 127;
  localparam int EXP_MAX  = 255;

  localparam logic [2:0] RM_RNE = 3'd0;  // nearest, ties to even
  localparam logic [2:0] RM_RTZ = 3'd1;
  localparam logic [2:0] RM_RDN = 3'd2;
  localparam logic [2:0] RM_RUP = 3'd3;

  localparam logic [30:0] QNAN_MAG = 31'h7FC0_0000;
  localparam logic [30:0] INF_MAG  = 31'h7F80_0000;

  localparam int PIPE_LAT = 4;

  // one float word, seen either whole or split into its fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic              sign;
      logic [EXP_W-1:0]  exp;
      logic [FRAC_W-1:0] frac;
    } f;
  } fp_word_t;

endpackage

//--- hdl/booth_pp_stage.sv
// stage 1: operand unpack, exception classes, exponent sum and registered radix-8 booth products
module booth_pp_stage (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                                            in_valid,
  input  logic [2:0]                                      r_mode,
  input  fpm_pkg::fp_word_t                               fp_x,
  input  fpm_pkg::fp_word_t                               fp_y,
  output logic                                            s1_valid,
  output logic [fpm_pkg::NUM_PP-1:0][fpm_pkg::PP_W-1:0]   pp,
  output logic [fpm_pkg::NUM_PP-1:0]                      pp_neg,
  output logic                                            sign_z,
  output logic [fpm_pkg::EXP_W:0]                         exp_sum,
  output logic                                            in_nan,
  output logic                                            in_inf,
  output logic                                            in_zer,
  output logic [2:0]                                      s1_r_mode
);

  logic [fpm_pkg::MANT_W-1:0] mant_x;  // recoded multiplier
  logic [fpm_pkg::MANT_W+1:0] mult_1x;  // multiplicand, room for 4x
  logic [fpm_pkg::MANT_W+1:0] mult_3x;
  logic [3*fpm_pkg::NUM_PP:0] rec;
  logic [fpm_pkg::NUM_PP-1:0][fpm_pkg::PP_W-1:0] pp_d;
  logic [fpm_pkg::NUM_PP-1:0] neg_d;
  logic exp_x_max;
  logic exp_y_max;
  logic zer_x;
  logic zer_y;
  logic nan_x;
  logic nan_y;
  logic inf_x;
  logic inf_y;

  assign mant_x  = {1'b1, fp_x.f.frac};
  assign mult_1x = {2'b00, 1'b1, fp_y.f.frac};
  assign mult_3x = (mult_1x << 1) + mult_1x;

  // zero below the lsb, zero pad on top so the last digit stays non-negative
  assign rec = {3'b000, mant_x, 1'b0};

  always_comb begin : booth_sel
    logic [3:0]                 trip;
    logic [fpm_pkg::MANT_W+1:0] mag;
    for (int i = 0; i < fpm_pkg::NUM_PP; i++) begin
      trip = rec[3*i +: 4];
      case (trip)
        4'b0000, 4'b1111:                   mag = '0;
        4'b0001, 4'b0010, 4'b1101, 4'b1110: mag = mult_1x;
        4'b0011, 4'b0100, 4'b1011, 4'b1100: mag = mult_1x << 1;
        4'b0101, 4'b0110, 4'b1001, 4'b1010: mag = mult_3x;
        default:                            mag = mult_1x << 2;  // +4 or -4
      endcase
      neg_d[i] = trip[3] & ~(&trip);
      // negative digit kept as ones complement, the +1 rides on pp_neg
      pp_d[i]  = neg_d[i] ? ~{1'b0, mag} : {1'b0, mag};
    end
  end

  assign exp_x_max = &fp_x.f.exp;
  assign exp_y_max = &fp_y.f.exp;
  assign zer_x     = ~|fp_x.f.exp;  // subnormals flush here
  assign zer_y     = ~|fp_y.f.exp;
  assign nan_x     = exp_x_max & (|fp_x.f.frac);
  assign nan_y     = exp_y_max & (|fp_y.f.frac);
  assign inf_x     = exp_x_max & ~(|fp_x.f.frac);
  assign inf_y     = exp_y_max & ~(|fp_y.f.frac);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      pp        <= pp_d;
      pp_neg    <= neg_d;
      sign_z    <= fp_x.f.sign ^ fp_y.f.sign;
      exp_sum   <= {1'b0, fp_x.f.exp} + {1'b0, fp_y.f.exp};
      in_nan    <= nan_x | nan_y | (exp_x_max & zer_y) | (exp_y_max & zer_x);
      in_inf    <= inf_x | inf_y;
      in_zer    <= zer_x | zer_y;
      s1_r_mode <= r_mode;
    end
  end

endmodule

//--- hdl/pp_sum_stage.sv
// stage 2: weighted sum of booth partial products and negation bits into the 48-bit product
module pp_sum_stage (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                                            s1_valid,
  input  logic [fpm_pkg::NUM_PP-1:0][fpm_pkg::PP_W-1:0]   pp,
  input  logic [fpm_pkg::NUM_PP-1:0]                      pp_neg,
  input  logic                                            sign_z,
  input  logic [fpm_pkg::EXP_W:0]                         exp_sum,
  input  logic                                            in_nan,
  input  logic                                            in_inf,
  input  logic                                            in_zer,
  input  logic [2:0]                                      s1_r_mode,
  output logic                                            s2_valid,
  output logic [fpm_pkg::PROD_W-1:0]                      prod,
  output logic                                            s2_sign_z,
  output logic [fpm_pkg::EXP_W:0]                         s2_exp_sum,
  output logic                                            s2_in_nan,
  output logic                                            s2_in_inf,
  output logic                                            s2_in_zer,
  output logic [2:0]                                      s2_r_mode
);

  logic [fpm_pkg::PROD_W-1:0] sum;

  // modulo 2^48 the sign extensions cancel, leaving the exact product
  always_comb begin : pp_add
    logic [fpm_pkg::PROD_W-1:0] term;
    logic [fpm_pkg::PROD_W-1:0] corr;
    sum = '0;
    for (int i = 0; i < fpm_pkg::NUM_PP; i++) begin
      term = {{(fpm_pkg::PROD_W-fpm_pkg::PP_W){pp[i][fpm_pkg::PP_W-1]}}, pp[i]};
      corr = {{(fpm_pkg::PROD_W-1){1'b0}}, pp_neg[i]};
      sum  = sum + (term << (3*i)) + (corr << (3*i));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      prod       <= sum;
      s2_sign_z  <= sign_z;
      s2_exp_sum <= exp_sum;
      s2_in_nan  <= in_nan;
      s2_in_inf  <= in_inf;
      s2_in_zer  <= in_zer;
      s2_r_mode  <= s1_r_mode;
    end
  end

endmodule

//--- hdl/norm_round_stage.sv
// stage 3: normalize the product, guard/round/sticky, rounding by mode, carry-out detect
module norm_round_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       s2_valid,
  input  logic [fpm_pkg::PROD_W-1:0] prod,
  input  logic [2:0]                 s2_r_mode,
  input  logic                       sign_z,
  input  logic [fpm_pkg::EXP_W:0]    exp_sum,
  input  logic                       in_nan,
  input  logic                       in_inf,
  input  logic                       in_zer,
  output logic                       s3_valid,
  output logic [fpm_pkg::FRAC_W-1:0] frac_z,
  output logic                       norm,
  output logic                       s3_sign_z,
  output logic [fpm_pkg::EXP_W:0]    s3_exp_sum,
  output logic                       s3_in_nan,
  output logic                       s3_in_inf,
  output logic                       s3_in_zer
);

  logic [fpm_pkg::PROD_W-1:0] p_sh;
  logic [fpm_pkg::MANT_W-1:0] kept;
  logic                       guard;
  logic                       rnd;
  logic                       sticky;
  logic                       inexact;
  logic                       inc;
  logic [fpm_pkg::MANT_W:0]   rounded;
  logic                       carry;
  logic [fpm_pkg::FRAC_W-1:0] frac_d;

  assign p_sh    = prod[fpm_pkg::PROD_W-1] ? prod : (prod << 1);
  assign kept    = p_sh[fpm_pkg::PROD_W-1 -: fpm_pkg::MANT_W];
  assign guard   = p_sh[fpm_pkg::PROD_W-fpm_pkg::MANT_W-1];
  assign rnd     = p_sh[fpm_pkg::PROD_W-fpm_pkg::MANT_W-2];
  assign sticky  = |p_sh[fpm_pkg::PROD_W-fpm_pkg::MANT_W-3:0];
  assign inexact = guard | rnd | sticky;

  always_comb begin
    case (s2_r_mode)
      fpm_pkg::RM_RNE: inc = guard & (rnd | sticky | kept[0]);
      fpm_pkg::RM_RTZ: inc = 1'b0;
      fpm_pkg::RM_RDN: inc = sign_z & inexact;  // away from zero when negative
      fpm_pkg::RM_RUP: inc = ~sign_z & inexact;
      default:         inc = guard;  // ties away
    endcase
  end

  assign rounded = {1'b0, kept} + {{fpm_pkg::MANT_W{1'b0}}, inc};
  assign carry   = rounded[fpm_pkg::MANT_W];
  assign frac_d  = carry ? rounded[fpm_pkg::FRAC_W:1] : rounded[fpm_pkg::FRAC_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s3_valid <= 1'b0;
    end else begin
      s3_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      frac_z     <= frac_d;
      norm       <= prod[fpm_pkg::PROD_W-1] | carry;
      s3_sign_z  <= sign_z;
      s3_exp_sum <= exp_sum;
      s3_in_nan  <= in_nan;
      s3_in_inf  <= in_inf;
      s3_in_zer  <= in_zer;
    end
  end

endmodule

//--- hdl/exp_pack_stage.sv
// stage 4: biased exponent, overflow/underflow, exception merge and registered result word
module exp_pack_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       s3_valid,
  input  logic [fpm_pkg::FRAC_W-1:0] frac_z,
  input  logic                       norm,
  input  logic                       sign_z,
  input  logic [fpm_pkg::EXP_W:0]    exp_sum,
  input  logic                       in_nan,
  input  logic                       in_inf,
  input  logic                       in_zer,
  output logic                       out_valid,
  output fpm_pkg::fp_word_t          fp_z,
  output logic                       ovrf,
  output logic                       udrf
);

  logic [fpm_pkg::EXP_W:0]   bias;
  logic [fpm_pkg::EXP_W+1:0] ovf_lim;
  logic [fpm_pkg::EXP_W-1:0] exp_z;
  logic                      ovrf_d;
  logic                      udrf_d;
  logic                      nan_f;
  logic                      inf_f;
  logic                      zer_f;
  fpm_pkg::fp_word_t         word;

  // product in [2,4) takes one off the bias
  assign bias    = norm ? 9'(fpm_pkg::EXP_BIAS - 1) : 9'(fpm_pkg::EXP_BIAS);
  assign ovf_lim = 10'(fpm_pkg::EXP_MAX) + {1'b0, bias};
  assign ovrf_d  = {1'b0, exp_sum} >= ovf_lim;
  assign udrf_d  = exp_sum <= bias;
  assign exp_z   = exp_sum[fpm_pkg::EXP_W-1:0] - bias[fpm_pkg::EXP_W-1:0];

  assign nan_f = in_nan;
  assign inf_f = in_inf | ovrf_d;
  assign zer_f = in_zer | udrf_d;

  always_comb begin
    word.f.sign = sign_z;
    word.f.exp  = exp_z;
    word.f.frac = frac_z;
    if (nan_f || (inf_f && zer_f)) begin
      word.raw = {sign_z, fpm_pkg::QNAN_MAG};
    end else if (inf_f) begin
      word.raw = {sign_z, fpm_pkg::INF_MAG};
    end else if (zer_f) begin
      word.raw = {sign_z, 31'd0};  // signed zero
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      ovrf      <= 1'b0;
      udrf      <= 1'b0;
    end else begin
      out_valid <= s3_valid;
      if (s3_valid) begin
        ovrf <= ovrf_d;
        udrf <= udrf_d;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s3_valid) begin
      fp_z <= word;
    end
  end

endmodule

//--- hdl/fpm_top.sv
// pipelined single-precision multiplier top, four stages chained with a valid strobe
module fpm_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  logic [2:0]        r_mode,
  input  fpm_pkg::fp_word_t fp_x,
  input  fpm_pkg::fp_word_t fp_y,
  output logic              out_valid,
  output fpm_pkg::fp_word_t fp_z,
  output logic              ovrf,
  output logic              udrf
);

  // stage 1 outputs
  logic                                          s1_valid;
  logic [fpm_pkg::NUM_PP-1:0][fpm_pkg::PP_W-1:0] pp;
  logic [fpm_pkg::NUM_PP-1:0]                    pp_neg;
  logic                                          s1_sign_z;
  logic [fpm_pkg::EXP_W:0]                       s1_exp_sum;
  logic                                          s1_in_nan;
  logic                                          s1_in_inf;
  logic                                          s1_in_zer;
  logic [2:0]                                    s1_r_mode;
  // stage 2 outputs
  logic                                          s2_valid;
  logic [fpm_pkg::PROD_W-1:0]                    prod;
  logic                                          s2_sign_z;
  logic [fpm_pkg::EXP_W:0]                       s2_exp_sum;
  logic                                          s2_in_nan;
  logic                                          s2_in_inf;
  logic                                          s2_in_zer;
  logic [2:0]                                    s2_r_mode;
  // stage 3 outputs
  logic                                          s3_valid;
  logic [fpm_pkg::FRAC_W-1:0]                    frac_z;
  logic                                          norm;
  logic                                          s3_sign_z;
  logic [fpm_pkg::EXP_W:0]                       s3_exp_sum;
  logic                                          s3_in_nan;
  logic                                          s3_in_inf;
  logic                                          s3_in_zer;

  booth_pp_stage u_booth_pp_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .r_mode   (r_mode),
    .fp_x     (fp_x),
    .fp_y     (fp_y),
    .s1_valid (s1_valid),
    .pp       (pp),
    .pp_neg   (pp_neg),
    .sign_z   (s1_sign_z),
    .exp_sum  (s1_exp_sum),
    .in_nan   (s1_in_nan),
    .in_inf   (s1_in_inf),
    .in_zer   (s1_in_zer),
    .s1_r_mode(s1_r_mode)
  );

  pp_sum_stage u_pp_sum_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .s1_valid  (s1_valid),
    .pp        (pp),
    .pp_neg    (pp_neg),
    .sign_z    (s1_sign_z),
    .exp_sum   (s1_exp_sum),
    .in_nan    (s1_in_nan),
    .in_inf    (s1_in_inf),
    .in_zer    (s1_in_zer),
    .s1_r_mode (s1_r_mode),
    .s2_valid  (s2_valid),
    .prod      (prod),
    .s2_sign_z (s2_sign_z),
    .s2_exp_sum(s2_exp_sum),
    .s2_in_nan (s2_in_nan),
    .s2_in_inf (s2_in_inf),
    .s2_in_zer (s2_in_zer),
    .s2_r_mode (s2_r_mode)
  );

  norm_round_stage u_norm_round_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .s2_valid  (s2_valid),
    .prod      (prod),
    .s2_r_mode (s2_r_mode),
    .sign_z    (s2_sign_z),
    .exp_sum   (s2_exp_sum),
    .in_nan    (s2_in_nan),
    .in_inf    (s2_in_inf),
    .in_zer    (s2_in_zer),
    .s3_valid  (s3_valid),
    .frac_z    (frac_z),
    .norm      (norm),
    .s3_sign_z (s3_sign_z),
    .s3_exp_sum(s3_exp_sum),
    .s3_in_nan (s3_in_nan),
    .s3_in_inf (s3_in_inf),
    .s3_in_zer (s3_in_zer)
  );

  exp_pack_stage u_exp_pack_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .s3_valid (s3_valid),
    .frac_z   (frac_z),
    .norm     (norm),
    .sign_z   (s3_sign_z),
    .exp_sum  (s3_exp_sum),
    .in_nan   (s3_in_nan),
    .in_inf   (s3_in_inf),
    .in_zer   (s3_in_zer),
    .out_valid(out_valid),
    .fp_z     (fp_z),
    .ovrf     (ovrf),
    .udrf     (udrf)
  );

endmodule

//--- testbench/fpm_props.sv
// concurrent assertions on the multiplier top level ports, bound to fpm_top
module fpm_props (
  input logic clk,
  input logic rst_n,
  input logic in_valid,
  input logic out_valid,
  input logic ovrf,
  input logic udrf
);

  // a reset cycle leaves out_valid low on the following edge
  reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
    else $error("out_valid high after a reset cycle");

  in_to_out_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid |-> ##(fpm_pkg::PIPE_LAT) out_valid
  ) else $error("out_valid missing %0d cycles after in_valid", fpm_pkg::PIPE_LAT);

  flags_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> !(ovrf && udrf)
  ) else $error("ovrf and udrf both high on a valid result");

endmodule

//--- testbench/tb_fpm.sv
// testbench for the pipelined multiplier: golden vectors sent in bursts, in-order result checks
module tb_fpm;

  localparam int NUM_VEC  = 30;
  localparam int WAIT_MAX = 200;

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  logic [2:0]        r_mode;
  fpm_pkg::fp_word_t fp_x;
  fpm_pkg::fp_word_t fp_y;
  logic              out_valid;
  fpm_pkg::fp_word_t fp_z;
  logic              ovrf;
  logic              udrf;

  // group, r_mode, fp_x, fp_y, fp_z, {ovrf, udrf}
  logic [107:0] vec [0:NUM_VEC-1];
  int           launch_cyc [$];
  int           cyc = 0;
  int           n_checked = 0;
  int           n_errors = 0;
  int           grp_total [16];
  int           grp_done [16];
  int           grp_err [16];
  integer       seed;
  bit           timed_out = 1'b0;

  fpm_top u_fpm_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .r_mode   (r_mode),
    .fp_x     (fp_x),
    .fp_y     (fp_y),
    .out_valid(out_valid),
    .fp_z     (fp_z),
    .ovrf     (ovrf),
    .udrf     (udrf)
  );

  bind fpm_top fpm_props u_fpm_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .out_valid(out_valid),
    .ovrf     (ovrf),
    .udrf     (udrf)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  function automatic string group_name(int g);
    case (g)
      1:       return "exact products";
      2:       return "rounding modes";
      3:       return "binade changes";
      4:       return "special operands";
      5:       return "overflow and underflow";
      default: return "mixed burst";
    endcase
  endfunction

  task automatic drive_vector(int i);
    in_valid = 1'b1;
    r_mode   = vec[i][102:100];
    fp_x.raw = vec[i][99:68];
    fp_y.raw = vec[i][67:36];
    launch_cyc.push_back(cyc);
  endtask

  // pairs the result with the oldest vector still in flight
  task automatic check_result();
    logic [107:0] v;
    int           g;
    int           lat;
    int           errs_before;
    if (launch_cyc.size() == 0) begin
      $display("out_valid raised at %0t with no input waiting for a result", $time);
      n_errors++;
    end else begin
      v           = vec[n_checked];
      g           = v[107:104];
      lat         = cyc - launch_cyc.pop_front();
      errs_before = n_errors;
      if (lat != fpm_pkg::PIPE_LAT) begin
        $display("ERR t=%0t latency expected %0d got %0d", $time, fpm_pkg::PIPE_LAT, lat);
        n_errors++;
      end
      if (fp_z.raw !== v[35:4]) begin
        $display("ERR t=%0t fp_z expected %h got %h", $time, v[35:4], fp_z.raw);
        n_errors++;
      end
      if (ovrf !== v[1]) begin
        $display("ERR t=%0t ovrf expected %b got %b", $time, v[1], ovrf);
        n_errors++;
      end
      if (udrf !== v[0]) begin
        $display("ERR t=%0t udrf expected %b got %b", $time, v[0], udrf);
        n_errors++;
      end
      grp_err[g] += n_errors - errs_before;
      grp_done[g]++;
      n_checked++;
      if (grp_done[g] == grp_total[g]) begin
        $display("group %0d %s: %0d vectors, %0d errors",
                 g, group_name(g), grp_total[g], grp_err[g]);
      end
    end
  endtask

  // outputs sampled mid-cycle
  always @(negedge clk) begin
    if (!rst_n) begin
      if (cyc > 0 && out_valid !== 1'b0) begin
        $display("out_valid high during reset at %0t", $time);
        n_errors++;
      end
    end else if (out_valid === 1'b1) begin
      check_result();
    end
  end

  initial begin
    int i;
    int burst;
    int gap;
    int waited;
    seed     = 16;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    r_mode   = '0;
    fp_x     = '0;
    fp_y     = '0;
    $readmemh("testbench/fpm_golden.hex", vec);
    for (i = 0; i < NUM_VEC; i++) begin
      grp_total[vec[i][107:104]]++;
    end
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;

    i = 0;
    while (i < NUM_VEC) begin
      burst = 1 + ($random(seed) & 7);
      while (burst > 0 && i < NUM_VEC) begin
        drive_vector(i);
        i++;
        burst--;
        @(posedge clk);
        #1;
      end
      in_valid = 1'b0;
      gap = 1 + ($random(seed) & 3);  // idle cycles between bursts
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end

    waited = 0;
    while (n_checked < NUM_VEC && waited < WAIT_MAX) begin
      @(posedge clk);
      waited++;
    end
    if (n_checked < NUM_VEC) begin
      $display("timeout: only %0d of %0d results arrived within %0d cycles",
               n_checked, NUM_VEC, WAIT_MAX);
      timed_out = 1'b1;
    end
    repeat (fpm_pkg::PIPE_LAT + 2) @(posedge clk);  // catch stray out_valid

    $display("checked %0d of %0d vectors, %0d errors", n_checked, NUM_VEC, n_errors);
    if (n_errors == 0 && !timed_out) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
hdl/fpm_pkg.sv
hdl/booth_pp_stage.sv
hdl/pp_sum_stage.sv
hdl/norm_round_stage.sv
hdl/exp_pack_stage.sv
hdl/fpm_top.sv
testbench/fpm_props.sv
testbench/tb_fpm.sv

//--- testbench/fpm_golden.hex
// columns: group _ r_mode _ fp_x _ fp_y _ expected fp_z _ expected {ovrf,udrf}
// groups: 1 exact, 2 rounding, 3 binade, 4 specials, 5 ovrf/udrf, 6 mixed
1_0_40000000_40400000_40C00000_0
1_1_40000000_40400000_40C00000_0
1_2_40400000_C0800000_C1400000_0
1_3_3F000000_3E800000_3E000000_0
1_4_40E00000_40A00000_420C0000_0
2_0_3F800003_3FC00000_3FC00004_0
2_4_3F800003_3FC00000_3FC00005_0
2_0_3F800001_3FC00000_3FC00002_0
2_1_BF800001_3FC00000_BFC00001_0
2_2_BF800001_3FC00000_BFC00002_0
2_3_BF800001_3FC00000_BFC00001_0
2_3_3F800001_3F800001_3F800003_0
2_5_BF800001_3FC00000_BFC00002_0
3_0_3FC00000_3FC00000_40100000_0
3_0_3FC00001_3FC00001_40100002_0
3_0_3FFFFFFE_3F800001_40000000_0
3_1_3FFFFFFE_3F800001_3FFFFFFF_0
4_0_7FC00000_3F800000_7FC00000_2
4_0_7F800000_C0000000_FF800000_2
4_0_80000000_3F800000_80000000_1
4_0_00400000_C0400000_80000000_0
4_0_7F800000_00000000_7FC00000_0
4_0_80000000_7F800000_FFC00000_0
5_0_7F000000_40000000_7F800000_2
5_0_7F7FFFFF_3FC00000_7F800000_2
5_0_00800000_3F000000_00000000_1
5_0_80800000_00800000_80000000_1
5_0_7F000000_3FFFFFFF_7F7FFFFF_0
6_0_41200000_41200000_42C80000_0
6_3_3DCCCCCD_41200000_3F800001_0
